//--- tb/lsu_input.txt
# name we size sign op_a op_b useincr reg_off wdata err
# expected: be mem_wdata misaligned load_result (all hex)
st_w0      1 0 0 00000100 00000000 0 0 11223344 0 f 11223344 0 00000000
st_h2      1 1 0 00000100 00000002 1 0 0000abcd 0 c abcd0000 0 00000000
st_b1      1 2 0 00000101 00000000 0 0 000000ee 0 2 0000ee00 0 00000000
st_b3_r2   1 3 0 00000103 00000000 0 2 00770000 0 8 77000000 0 00000000
st_h0_r2   1 1 0 00000104 00000000 0 2 12340000 0 3 00001234 0 00000000
st_b0_r1   1 2 0 00000108 00000000 0 1 00005500 0 1 00000055 0 00000000
st_b2      1 2 0 0000010a 00000000 0 0 000000c3 0 4 00c30000 0 00000000
ld_b0u     0 2 0 00000110 00000000 0 0 00000000 0 1 00000000 0 0000004a
ld_b1s     0 2 1 000001a0 00000005 1 0 00000000 0 2 00000000 0 ffffffff
ld_b3s     0 3 1 000001b3 00000000 0 0 00000000 0 8 00000000 0 ffffffe9
ld_b2u     0 2 0 000001b2 00000000 0 0 00000000 0 4 00000000 0 000000e8
ld_h0s     0 1 1 000001c0 00000000 0 0 00000000 0 3 00000000 0 ffff9b9a
ld_h2u     0 1 0 000001c2 00000000 0 0 00000000 0 c 00000000 0 00009998
ld_h1s     0 1 1 00000121 00000000 0 0 00000000 0 6 00000000 0 0000787b
ld_w0      0 0 0 00000130 00000000 0 0 00000000 0 f 00000000 0 69686b6a
ld_w1_mis  0 0 0 00000140 00000001 1 0 00000000 0 e 00000000 1 1e19181b
ld_h3_mis  0 1 1 000001f3 00000000 0 0 00000000 0 8 00000000 1 ffffaea9
st_w2_mis  1 0 0 00000150 00000002 1 0 a1b2c3d4 0 c c3d4a1b2 1 00000000
st_h3_mis  1 1 0 00000163 00000000 0 0 00005a6b 0 8 6b00005a 1 00000000
ld_w3_mis  0 0 0 00000173 00000000 0 0 00000000 0 8 00000000 1 2c2f2e29
err_ld     0 0 0 00000180 00000000 0 0 00000000 1 f 00000000 0 d9d8dbda
err_st     1 2 0 00000182 00000000 0 0 00000099 1 4 00990000 0 00000000

//--- sources.f
src/lsu_mem_pkg.sv
src/lsu_op_pkg.sv
src/lsu_request_gen.sv
src/lsu_load_align.sv
src/lsu_bus_ctrl.sv
src/load_store_unit.sv
tb/tb_clock_gen.sv
tb/tb_load_store_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the load store unit testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_load_store_unit \
  -f sources.f \
  -o sim_lsu \
  && ./obj_dir/sim_lsu | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && exit 0 \
  || exit 1

//--- tb/tb_load_store_unit.sv
// load store unit testbench: memory model, execute stage driver, checks and watchdog
module tb_load_store_unit;

  logic clk, rst_n;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  lsu_mem_pkg::byte_en_t data_be_o;
  logic data_we_ex_i, data_sign_ext_ex_i, data_req_ex_i, addr_useincr_ex_i;
  lsu_op_pkg::access_size_e data_type_ex_i;
  lsu_op_pkg::byte_offset_t data_reg_offset_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic data_misaligned_ex_i, data_misaligned_o, load_err_o, store_err_o;
  logic lsu_ready_ex_o, lsu_ready_wb_o, ex_valid_i, busy_o;

  // test table, one entry per line of the data file
  string       t_name [64];
  logic [31:0] t_we [64], t_size [64], t_sign [64], t_opa [64], t_opb [64], t_incr [64];
  logic [31:0] t_roff [64], t_wdata [64], t_err [64], t_be [64], t_exp_wd [64];
  logic [31:0] t_mis [64], t_exp_rd [64];
  int          num_tests = 0;
  logic        tests_loaded = 1'b0;
  string       cur_name = "reset";
  int          mismatch_cnt = 0;  // wrong values
  int          fail_cnt = 0;      // protocol and other failures
  logic [31:0] lfsr_q = 32'h3dd4;
  logic        rv_pending = 1'b0;  // rvalid due next cycle
  logic [31:0] rv_addr;

  tb_clock_gen u_tb_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  load_store_unit u_load_store_unit (.*);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [3:0] draw_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // memory content: every byte is its low address byte xor 5a
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] base;
    logic [31:0] w;
    base = {addr[31:2], 2'b00};
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = 8'(base + 32'(k)) ^ 8'h5a;
    return w;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else
    begin
      mismatch_cnt++;
      $display("mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1)
    else
    begin
      fail_cnt++;
      $display("error in %s: %s", cur_name, msg);
    end
  endtask

  // falling edge: memory side inputs for the new cycle
  task next_cycle;
    @(negedge clk);
    data_gnt_i    = 1'b0;
    data_err_i    = 1'b0;
    data_rvalid_i = rv_pending;
    data_rdata_i  = rv_pending ? mem_word(rv_addr) : 32'h0;
    rv_pending    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // one address phase, held until the random grant
  ////////////////////////////////////////////////////////////

  task issue_part(input logic [31:0] opa, input logic [31:0] opb, input logic incr,
                  input logic [1:0] roff, input logic mis_ex, input logic [31:0] exp_be,
                  input logic [31:0] exp_wd, input logic exp_mis, input logic err,
                  output logic got_mis);
    logic [3:0]  delay;
    logic        first;
    logic        granted;
    logic [31:0] s_addr, s_wd;
    logic [3:0]  s_be;
    delay   = draw_bits(2);  // 0..3 cycles of back-pressure
    first   = 1'b1;
    granted = 1'b0;
    got_mis = 1'b0;
    operand_a_ex_i       = opa;
    operand_b_ex_i       = opb;
    addr_useincr_ex_i    = incr;
    data_reg_offset_ex_i = roff;
    data_misaligned_ex_i = mis_ex;
    data_req_ex_i        = 1'b1;
    while (!granted)
    begin
      #1;
      data_err_i = err;  // error line up while waiting too, only the grant may pass it
      if (data_req_o && delay == 0)
        data_gnt_i = 1'b1;
      #39;  // sample just before the rising edge
      if (first)
      begin
        s_addr = data_addr_o;
        s_be   = data_be_o;
        s_wd   = data_wdata_o;
        first  = 1'b0;
      end
      else
        check_true(s_addr == data_addr_o && s_be == data_be_o && s_wd == data_wdata_o,
                   "address phase changed while waiting for grant");
      check_val("addr", incr ? opa + opb : opa, data_addr_o);
      if (data_gnt_i)
      begin
        check_val("be", exp_be, 32'(data_be_o));
        check_val("wdata", exp_wd, data_wdata_o);
        check_val("we", 32'(data_we_ex_i), 32'(data_we_o));
        check_val("misaligned", 32'(exp_mis), 32'(data_misaligned_o));
        check_true(lsu_ready_ex_o, "ready_ex low in the grant cycle");
        check_val("load_err", 32'(err & ~data_we_ex_i), 32'(load_err_o));
        check_val("store_err", 32'(err & data_we_ex_i), 32'(store_err_o));
        got_mis    = data_misaligned_o;
        rv_pending = 1'b1;  // response exactly one cycle later
        rv_addr    = data_addr_o;
        granted    = 1'b1;
      end
      else
      begin
        check_true(data_req_o, "request dropped before grant");
        check_true(!lsu_ready_ex_o, "ready_ex high while waiting for grant");
        check_true(!load_err_o && !store_err_o, "error raised without grant");
        if (delay != 0)
          delay--;
      end
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one line of the table, split and stall included
  ////////////////////////////////////////////////////////////

  task run_test(input int t);
    logic        stall;
    logic        got_mis;
    logic        dummy;
    logic [31:0] addr;
    logic [1:0]  off;
    logic [31:0] be2;
    logic [3:0]  n;
    stall = 1'b0;
    if (t_mis[t] == 0 && t_err[t] == 0)
      stall = draw_bits(1) == 4'd1;  // half the plain accesses stall
    cur_name           = t_name[t];
    data_we_ex_i       = t_we[t][0];
    data_type_ex_i     = lsu_op_pkg::access_size_e'(t_size[t][1:0]);
    data_sign_ext_ex_i = t_sign[t][0];
    data_wdata_ex_i    = t_wdata[t];
    ex_valid_i         = !stall;
    issue_part(t_opa[t], t_opb[t], t_incr[t][0], t_roff[t][1:0], 1'b0, t_be[t],
               t_exp_wd[t], t_mis[t][0], t_err[t][0], got_mis);
    if (got_mis)
    begin
      addr = t_incr[t][0] ? t_opa[t] + t_opb[t] : t_opa[t];
      off  = addr[1:0];
      // spilled lanes: below the offset for a word, lane 0 for a half
      be2  = 32'd1;
      if (t_size[t][1:0] == 2'b00)
      begin
        be2 = '0;
        for (int i = 0; i < 4; i++)
          if (i < int'(off))
            be2[i] = 1'b1;
      end
      // next aligned word in operand a, the byte offset rides in operand b
      issue_part({addr[31:2], 2'b00} + 32'd4, 32'(off), 1'b1, t_roff[t][1:0], 1'b1,
                 be2, t_exp_wd[t], 1'b0, 1'b0, dummy);
    end
    data_req_ex_i        = 1'b0;
    data_misaligned_ex_i = 1'b0;
    #40;  // rvalid cycle of the last part
    check_true(lsu_ready_wb_o, "ready_wb low in the rvalid cycle");
    if (!t_we[t][0])
      check_val("rdata", t_exp_rd[t], data_rdata_ex_o);
    if (stall)
    begin
      check_true(busy_o, "busy low during execute stall");
      n = draw_bits(1) + 4'd1;
      repeat (n)
      begin
        next_cycle();
        #40;
        check_true(busy_o, "busy low during execute stall");
      end
      next_cycle();
      ex_valid_i = 1'b1;  // stall ends
    end
    next_cycle();
    #40;
    check_true(!busy_o, "busy still high after the access");
    if (!t_we[t][0])
      check_val("held rdata", t_exp_rd[t], data_rdata_ex_o);
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin : drive_proc
    int    fd;
    int    code;
    string line;
    string nm;
    logic [31:0] v [13];
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i = 1'b0;
    data_rdata_i = '0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = lsu_op_pkg::SIZE_WORD;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    data_sign_ext_ex_i = 1'b0;
    data_req_ex_i = 1'b0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    ex_valid_i = 1'b1;
    fd = $fopen("tb/lsu_input.txt", "r");
    if (fd == 0)
      check_true(1'b0, "cannot open tb/lsu_input.txt");
    else
    begin
      while (!$feof(fd) && num_tests < 64)
      begin
        line = "";
        code = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm, v[0], v[1],
                         v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]);
          if (code == 14)
          begin
            t_name[num_tests] = nm;
            t_we[num_tests] = v[0];
            t_size[num_tests] = v[1];
            t_sign[num_tests] = v[2];
            t_opa[num_tests] = v[3];
            t_opb[num_tests] = v[4];
            t_incr[num_tests] = v[5];
            t_roff[num_tests] = v[6];
            t_wdata[num_tests] = v[7];
            t_err[num_tests] = v[8];
            t_be[num_tests] = v[9];
            t_exp_wd[num_tests] = v[10];
            t_mis[num_tests] = v[11];
            t_exp_rd[num_tests] = v[12];
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
    tests_loaded = 1'b1;
    wait (rst_n === 1'b1);
    next_cycle();
    #40;
    check_true(!data_req_o && !busy_o && !load_err_o && !store_err_o && !data_misaligned_o,
               "outputs not idle after reset");
    check_true(lsu_ready_ex_o && lsu_ready_wb_o, "ready outputs low after reset");
    next_cycle();
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("closing: %0d tests, %0d mismatches, %0d other errors",
             num_tests, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && num_tests > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog, sized from the table length
  initial
  begin : watchdog_proc
    wait (tests_loaded);
    repeat (num_tests * 12 + 20) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", num_tests * 12 + 20);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock and reset source: 100 unit period, reset held low for two cycles
module tb_clock_gen
(
  output logic clk_o,   // free running clock
  output logic rst_n_o  // active low reset
);

  initial
  begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // half period
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // release away from the active edge
  end

endmodule

//--- src/load_store_unit.sv
// load store unit top: joins request generation, bus control and load alignment
module load_store_unit
(
  input  logic                           clk,
  input  logic                           rst_n,

  // data memory
  output logic                           data_req_o,
  input  logic                           data_gnt_i,
  input  logic                           data_rvalid_i,
  input  logic                           data_err_i,
  output logic [lsu_mem_pkg::DATA_W-1:0] data_addr_o,
  output logic                           data_we_o,
  output lsu_mem_pkg::byte_en_t          data_be_o,
  output logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_o,
  input  logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_i,

  // execute stage
  input  logic                           data_we_ex_i,
  input  lsu_op_pkg::access_size_e       data_type_ex_i,
  input  logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_ex_i,
  input  lsu_op_pkg::byte_offset_t       data_reg_offset_ex_i,
  input  logic                           data_sign_ext_ex_i,
  output logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_ex_o,
  input  logic                           data_req_ex_i,
  input  logic [lsu_mem_pkg::DATA_W-1:0] operand_a_ex_i,
  input  logic [lsu_mem_pkg::DATA_W-1:0] operand_b_ex_i,
  input  logic                           addr_useincr_ex_i,
  input  logic                           data_misaligned_ex_i,  // second part of a split
  output logic                           data_misaligned_o,     // split needed, to controller

  // exceptions and stalls
  output logic                           load_err_o,
  output logic                           store_err_o,
  output logic                           lsu_ready_ex_o,
  output logic                           lsu_ready_wb_o,
  input  logic                           ex_valid_i,
  output logic                           busy_o
);

  assign data_we_o = data_we_ex_i;  // direction needs no processing

  ////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////

  lsu_request_gen u_lsu_request_gen
  (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .data_addr_o       (data_addr_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .data_misaligned_o (data_misaligned_o)
  );

  lsu_bus_ctrl u_lsu_bus_ctrl
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_we_i      (data_we_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

  // data phase
  lsu_load_align u_lsu_load_align
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .data_gnt_i          (data_gnt_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_rdata_i        (data_rdata_i),
    .data_type_i         (data_type_ex_i),
    .data_sign_ext_i     (data_sign_ext_ex_i),
    .data_we_i           (data_we_ex_i),
    .addr_offset_i       (data_addr_o[1:0]),  // offset of the generated address
    .data_misaligned_i   (data_misaligned_ex_i),
    .data_misaligned_o_i (data_misaligned_o),
    .data_rdata_ex_o     (data_rdata_ex_o)
  );

endmodule

//--- src/lsu_bus_ctrl.sv
// lsu bus controller: request/grant/response FSM with execute stall handling and errors
module lsu_bus_ctrl
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,   // execute stage requests an access
  input  logic data_gnt_i,      // memory accepts the address phase
  input  logic data_rvalid_i,   // memory returns the data phase
  input  logic data_err_i,      // bus error on the granted access
  input  logic data_we_i,       // direction of the current request
  input  logic ex_valid_i,      // execute stage is not stalled

  output logic data_req_o,      // request to memory
  output logic lsu_ready_ex_o,  // execute stage may advance
  output logic lsu_ready_wb_o,  // write-back stage may advance
  output logic busy_o,          // something in flight
  output logic load_err_o,      // bus error on a load
  output logic store_err_o      // bus error on a store
);

  typedef enum logic [1:0] {
    IDLE,                  // nothing outstanding
    WAIT_RVALID,           // one access outstanding
    WAIT_RVALID_EX_STALL,  // outstanding, execute stage stalled at grant
    IDLE_EX_STALL          // done, waiting for the stall to clear
  } lsu_state_e;

  lsu_state_e state_q, state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////
  // next state and handshake
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = data_req_ex_i;  // zero latency issue
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // hold ex until grant
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;  // wb waits for the response
        if (data_rvalid_i)
        begin
          data_req_o = data_req_ex_i;  // back-to-back issue
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;  // keep asking from IDLE
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      WAIT_RVALID_EX_STALL:
      begin
        // no new request here, ex has not consumed the last one yet
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;  // stall gone, normal wait
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  assign busy_o = (state_q != IDLE) || data_req_o;

  // errors belong to the accepted access only
  assign load_err_o  = data_req_o & data_gnt_i & data_err_i & ~data_we_i;
  assign store_err_o = data_req_o & data_gnt_i & data_err_i &  data_we_i;

endmodule

//--- src/lsu_load_align.sv
// lsu load aligner: latches access attributes on grant, assembles and extends read data
module lsu_load_align
(
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           data_gnt_i,           // address phase accepted
  input  logic                           data_rvalid_i,        // read data is on the bus
  input  logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_i,         // raw memory word

  input  lsu_op_pkg::access_size_e       data_type_i,          // size of the granted access
  input  logic                           data_sign_ext_i,      // sign extend the result
  input  logic                           data_we_i,            // store, no result
  input  lsu_op_pkg::byte_offset_t       addr_offset_i,        // low address bits
  input  logic                           data_misaligned_i,    // second part on the ex side
  input  logic                           data_misaligned_o_i,  // first part of a split

  output logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_ex_o       // result to the pipeline
);

  // attributes of the access in flight
  lsu_op_pkg::access_size_e        type_q;
  logic                            sign_ext_q;
  logic                            we_q;
  lsu_op_pkg::byte_offset_t        offset_q;

  lsu_mem_pkg::data_word_u         rdata_q;    // held result or first half of a split
  lsu_mem_pkg::data_word_u         rdata_u;    // incoming word, decoded
  logic [lsu_mem_pkg::DATA_W-1:0]  word_asm;   // word result, possibly assembled
  logic [15:0]                     half_sel;   // selected halfword
  logic [7:0]                      byte_sel;   // selected byte
  logic [lsu_mem_pkg::DATA_W-1:0]  rdata_ext;  // final extended value

  ////////////////////////////////////////////////////////////
  // capture on grant
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= lsu_op_pkg::SIZE_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= '0;
    end
    else if (data_gnt_i)
    begin
      type_q     <= data_type_i;
      sign_ext_q <= data_sign_ext_i;
      we_q       <= data_we_i;
      offset_q   <= addr_offset_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // extraction and extension
  ////////////////////////////////////////////////////////////

  assign rdata_u = data_rdata_i;

  always_comb
  begin
    // word: upper lanes of the first part below the low lanes of the new word
    case (offset_q)
      2'b00:   word_asm = rdata_u;
      2'b01:   word_asm = {rdata_u.bytes[0], rdata_q.bytes[3:1]};
      2'b10:   word_asm = {rdata_u.halves[0], rdata_q.halves[1]};
      default: word_asm = {rdata_u.bytes[2:0], rdata_q.bytes[3]};
    endcase

    // half: offset 3 only happens as the second part of a split
    case (offset_q)
      2'b00:   half_sel = rdata_u.halves[0];
      2'b01:   half_sel = {rdata_u.bytes[2], rdata_u.bytes[1]};
      2'b10:   half_sel = rdata_u.halves[1];
      default: half_sel = {rdata_u.bytes[0], rdata_q.bytes[3]};
    endcase

    byte_sel = rdata_u.bytes[offset_q];  // bytes never split
  end

  always_comb
  begin
    case (type_q)
      lsu_op_pkg::SIZE_WORD:
        rdata_ext = word_asm;
      lsu_op_pkg::SIZE_HALF:
        rdata_ext = {{16{sign_ext_q & half_sel[15]}}, half_sel};
      lsu_op_pkg::SIZE_BYTE,
      lsu_op_pkg::SIZE_BYTE_HI:
        rdata_ext = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};
      default:
        rdata_ext = word_asm;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////

  // first part of a split keeps the raw word for assembly later,
  // any other load keeps what went to the pipeline
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
    begin
      if (data_misaligned_i || data_misaligned_o_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // live in rvalid cycle

endmodule

//--- src/lsu_request_gen.sv
// lsu request generator: address, byte enables, store data rotation and split detection
module lsu_request_gen
(
  input  logic [lsu_mem_pkg::DATA_W-1:0] operand_a_i,        // base operand
  input  logic [lsu_mem_pkg::DATA_W-1:0] operand_b_i,        // increment operand
  input  logic                           addr_useincr_i,     // add operand b to a
  input  lsu_op_pkg::access_size_e       data_type_i,        // word / half / byte
  input  logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_i,       // store data as held in reg
  input  lsu_op_pkg::byte_offset_t       data_reg_offset_i,  // byte position inside reg
  input  logic                           data_req_i,         // execute stage wants access
  input  logic                           data_misaligned_i,  // this is the second part

  output logic [lsu_mem_pkg::DATA_W-1:0] data_addr_o,        // memory address
  output lsu_mem_pkg::byte_en_t          data_be_o,          // lane enables
  output logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_o,       // lane-aligned store data
  output logic                           data_misaligned_o   // a second part is needed
);

  lsu_op_pkg::byte_offset_t              addr_off;      // low address bits
  lsu_op_pkg::byte_offset_t              wdata_offset;  // store rotation in bytes
  logic [2*lsu_mem_pkg::DATA_W-1:0]      wdata_dbl;     // doubled word for rotation

  ////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////

  assign data_addr_o = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off    = data_addr_o[1:0];

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    data_be_o = '0;
    case (data_type_i)
      lsu_op_pkg::SIZE_WORD:
      begin
        if (!data_misaligned_i)
          data_be_o = {lsu_mem_pkg::NUM_LANES{1'b1}} << addr_off;  // lanes off..3
        else
          data_be_o = (lsu_mem_pkg::byte_en_t'(1) << addr_off) - lsu_mem_pkg::byte_en_t'(1);
          // spilled part takes the lanes below the offset
      end
      lsu_op_pkg::SIZE_HALF:
      begin
        if (!data_misaligned_i)
          data_be_o = lsu_mem_pkg::byte_en_t'(2'b11) << addr_off;  // top bit drops at off 3
        else
          data_be_o = lsu_mem_pkg::byte_en_t'(1);  // only lane 0 spills
      end
      lsu_op_pkg::SIZE_BYTE,
      lsu_op_pkg::SIZE_BYTE_HI:
      begin
        data_be_o = lsu_mem_pkg::byte_en_t'(1) << addr_off;  // never split
      end
      default:
      begin
        data_be_o = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store data
  ////////////////////////////////////////////////////////////

  // the register byte at data_reg_offset_i has to land on lane addr_off,
  // so rotate left by the difference, modulo the word
  assign wdata_offset = addr_off - data_reg_offset_i;
  assign wdata_dbl    = {data_wdata_i, data_wdata_i} << {wdata_offset, 3'b000};
  assign data_wdata_o = wdata_dbl[2*lsu_mem_pkg::DATA_W-1 -: lsu_mem_pkg::DATA_W];  // upper copy

  ////////////////////////////////////////////////////////////
  // split detection
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i)  // only a first part can split
    begin
      if ((data_type_i == lsu_op_pkg::SIZE_WORD) && (addr_off != 2'b00))
        data_misaligned_o = 1'b1;  // word crosses the boundary
      if ((data_type_i == lsu_op_pkg::SIZE_HALF) && (addr_off == 2'b11))
        data_misaligned_o = 1'b1;  // half straddles lanes 3 and 0
    end
  end

endmodule

//--- src/lsu_op_pkg.sv
// lsu operation package: access size encoding and byte offset of a load/store
package lsu_op_pkg;

  ////////////////////////////////////////////////////////////
  // access size
  ////////////////////////////////////////////////////////////

  // size as delivered by the execute stage
  // byte accesses arrive with either code 2 or 3
  typedef enum logic [1:0] {
    SIZE_WORD    = 2'b00,  // 32 bit
    SIZE_HALF    = 2'b01,  // 16 bit
    SIZE_BYTE    = 2'b10,  // 8 bit
    SIZE_BYTE_HI = 2'b11   // 8 bit, second encoding
  } access_size_e;

  ////////////////////////////////////////////////////////////
  // position inside a word
  ////////////////////////////////////////////////////////////

  // byte offset, i.e. the two low address bits
  // also used for the register-side offset of store data
  typedef logic [1:0] byte_offset_t;

endpackage

//--- src/lsu_mem_pkg.sv
// lsu memory bus package: bus widths, byte-enable type and the decoded data word
package lsu_mem_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W    = 32;  // data and address width
  localparam int unsigned NUM_LANES = 4;   // byte lanes in one word

  // one enable per byte lane, bit 0 is the lowest address
  typedef logic [NUM_LANES-1:0] byte_en_t;

  ////////////////////////////////////////////////////////////
  // data word views
  ////////////////////////////////////////////////////////////

  // a bus word seen either as bytes or as halfwords
  // index 0 is always the least significant part
  typedef union packed {
    logic [NUM_LANES-1:0][7:0] bytes;   // byte lane view
    logic [1:0][15:0]          halves;  // halfword view
  } data_word_u;

endpackage
